// ==== common/ttt_defines.svh ====
`ifndef TTT_DEFINES_SVH
`define TTT_DEFINES_SVH

// engine size
`define TTT_NUM_PROCESSORS 10
`define TTT_NUM_CONNECTIONS 50

// widths, the id width also holds the sentinel source id
`define TTT_PROC_ID_BITS 4
`define TTT_CONN_ID_BITS 6
`define TTT_NEW_TOKENS_BITS 4
`define TTT_TOKENS_BITS 8
`define TTT_PROG_BITS 8

// every threshold comes out of reset at this value
`define TTT_DEFAULT_THRESHOLD 1

// instruction word: upper two bits select the target, low bits the command
`define TTT_INSTR_NET 2'b11
`define TTT_INSTR_PROC 2'b10
`define TTT_EXEC_READ_INPUT 3'b001
`define TTT_EXEC_ADVANCE 3'b010

`endif

// ==== common/ttt_net_if.sv ====
`timescale 1ns/10ps
`include "ttt_defines.svh"

interface ttt_net_if import ttt_pkg::*; ();

    // request side, from the sequencer
    net_op_e                         op;
    logic [`TTT_PROC_ID_BITS-1:0]    source_id;
    logic [`TTT_CONN_ID_BITS-1:0]    connection_id;
    prog_word_u                      prog;

    // walker results, from the network
    logic [`TTT_PROC_ID_BITS-1:0]    target_id;
    token_pair_t                     weights;
    logic                            valid;
    logic                            done;

    modport master (
        output op, source_id, connection_id, prog,
        input  target_id, weights, valid, done
    );

    modport slave (
        input  op, source_id, connection_id, prog,
        output target_id, weights, valid, done
    );

endinterface

// ==== common/ttt_pkg.sv ====
`include "ttt_defines.svh"

package ttt_pkg;

    // round stages, visible on the stage port
    typedef enum logic [2:0] {
        STAGE_INPUT  = 3'd0,
        STAGE_UPDATE = 3'd1,
        STAGE_SCAN   = 3'd2,
        STAGE_FANOUT = 3'd3
    } stage_e;

    // processor array operations
    typedef enum logic [2:0] {
        PROC_NOP          = 3'b000,
        PROC_SET_GOOD_THR = 3'b001,
        PROC_SET_BAD_THR  = 3'b010,
        PROC_ADD          = 3'b100,
        PROC_UPDATE       = 3'b101
    } proc_op_e;

    // network operations
    typedef enum logic [2:0] {
        NET_NOP         = 3'b000,
        NET_SET_FIRST   = 3'b001,
        NET_SET_TARGET  = 3'b010,
        NET_SET_WEIGHTS = 3'b011,
        NET_START       = 3'b110,
        NET_STEP        = 3'b111
    } net_op_e;

    // signed good and bad amounts, good in the upper half
    typedef struct packed {
        logic signed [`TTT_NEW_TOKENS_BITS-1:0] good;
        logic signed [`TTT_NEW_TOKENS_BITS-1:0] bad;
    } token_pair_t;

    // programming data, either a weight pair or a plain value
    typedef union packed {
        token_pair_t                  weights;
        logic [`TTT_PROG_BITS-1:0]    value;
    } prog_word_u;

endpackage

// ==== common/ttt_proc_if.sv ====
`timescale 1ns/10ps
`include "ttt_defines.svh"

interface ttt_proc_if import ttt_pkg::*; ();

    // command side, from the sequencer
    proc_op_e                        op;
    logic [`TTT_PROC_ID_BITS-1:0]    processor_id;
    token_pair_t                     tokens;
    prog_word_u                      prog;

    // update result, one cycle after PROC_UPDATE
    // bit 1 is start, bit 0 is stop
    logic [1:0]                      startstop;

    modport master (
        output op, processor_id, tokens, prog,
        input  startstop
    );

    modport slave (
        input  op, processor_id, tokens, prog,
        output startstop
    );

endinterface

// ==== logic/ttt_main.sv ====
`timescale 1ns/10ps
`include "ttt_defines.svh"

module ttt_main (
    input  logic                                reset,
    input  logic                                clock_fast,
    output logic [2:0]                          stage,
    input  logic [`TTT_PROC_ID_BITS-1:0]        processor_id_in,
    output logic [`TTT_PROC_ID_BITS-1:0]        processor_id_out,
    input  logic [`TTT_NEW_TOKENS_BITS-1:0]     good_tokens_in,
    input  logic [`TTT_NEW_TOKENS_BITS-1:0]     bad_tokens_in,
    output logic [1:0]                          token_startstop,
    output logic                                output_valid,
    input  logic [4:0]                          instruction,
    input  logic [`TTT_CONN_ID_BITS-1:0]        connection_id_in,
    input  logic [`TTT_PROG_BITS-1:0]           prog_data
);
    // sequencer to network, sequencer to processors
    ttt_net_if  net_bus ();
    ttt_proc_if proc_bus ();

    ttt_sequencer seq (
        .clock_fast       (clock_fast),
        .reset            (reset),
        .instruction      (instruction),
        .processor_id_in  (processor_id_in),
        .connection_id_in (connection_id_in),
        .prog_data        (prog_data),
        .good_tokens_in   (good_tokens_in),
        .bad_tokens_in    (bad_tokens_in),
        .stage            (stage),
        .processor_id_out (processor_id_out),
        .token_startstop  (token_startstop),
        .output_valid     (output_valid),
        .net              (net_bus.master),
        .proc             (proc_bus.master)
    );

    ttt_network net (
        .clock_fast (clock_fast),
        .reset      (reset),
        .bus        (net_bus.slave)
    );

    ttt_processor_array procs (
        .clock_fast (clock_fast),
        .reset      (reset),
        .bus        (proc_bus.slave)
    );

endmodule

// ==== network/ttt_network.sv ====
`timescale 1ns/10ps
`include "ttt_defines.svh"

module ttt_network import ttt_pkg::*; (
    input  logic        clock_fast,
    input  logic        reset,
    ttt_net_if.slave    bus
);
    localparam int NUM_PROC = `TTT_NUM_PROCESSORS;
    localparam int NUM_CONN = `TTT_NUM_CONNECTIONS;
    localparam int ID_BITS = `TTT_PROC_ID_BITS;
    localparam int CONN_BITS = `TTT_CONN_ID_BITS;

    // first connection of each source, the extra entry closes the last range
    logic [CONN_BITS-1:0] first_conn [NUM_PROC+1];
    // connection memory
    logic [ID_BITS-1:0] target_mem [NUM_CONN];
    token_pair_t weight_mem [NUM_CONN];

    // walker position and end of range, exclusive
    logic [CONN_BITS-1:0] walk_idx;
    logic [CONN_BITS-1:0] walk_end;
    logic more_entries;

    assign more_entries = (walk_idx != walk_end);

    always_ff @(posedge clock_fast) begin
        if (reset) begin
            walk_idx <= '0;
            walk_end <= '0;
            bus.valid <= 1'b0;
            bus.done <= 1'b0;
            for (int i = 0; i <= NUM_PROC; i++) begin
                first_conn[i] <= '0;
            end
        end else begin
            bus.valid <= 1'b0;
            bus.done <= 1'b0;
            case (bus.op)
                NET_SET_FIRST: begin
                    if (bus.source_id <= ID_BITS'(NUM_PROC)) begin
                        first_conn[bus.source_id] <= bus.prog.value[CONN_BITS-1:0];
                    end
                end
                NET_START: begin
                    walk_idx <= first_conn[bus.source_id];
                    walk_end <= first_conn[bus.source_id + 1'b1];
                    // empty range finishes at once
                    bus.done <= (first_conn[bus.source_id] == first_conn[bus.source_id + 1'b1]);
                end
                NET_STEP: begin
                    if (more_entries) begin
                        bus.valid <= 1'b1;
                        walk_idx <= walk_idx + 1'b1;
                    end else begin
                        bus.done <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // memory writes and entry readout
    always_ff @(posedge clock_fast) begin
        if (bus.op == NET_SET_TARGET && bus.connection_id < CONN_BITS'(NUM_CONN)) begin
            target_mem[bus.connection_id] <= bus.prog.value[ID_BITS-1:0];
        end
        if (bus.op == NET_SET_WEIGHTS && bus.connection_id < CONN_BITS'(NUM_CONN)) begin
            weight_mem[bus.connection_id] <= bus.prog.weights;
        end
        if (bus.op == NET_STEP && more_entries) begin
            bus.target_id <= target_mem[walk_idx];
            bus.weights <= weight_mem[walk_idx];
        end
    end

endmodule

// ==== processor/ttt_processor_array.sv ====
`timescale 1ns/10ps
`include "ttt_defines.svh"

module ttt_processor_array import ttt_pkg::*; (
    input  logic        clock_fast,
    input  logic        reset,
    ttt_proc_if.slave   bus
);
    localparam int NUM_PROC = `TTT_NUM_PROCESSORS;
    localparam int TOK_BITS = `TTT_TOKENS_BITS;
    localparam int NEW_BITS = `TTT_NEW_TOKENS_BITS;
    localparam logic signed [TOK_BITS:0] CNT_MAX = (2 ** (TOK_BITS - 1)) - 1;
    localparam logic signed [TOK_BITS:0] CNT_MIN = -(2 ** (TOK_BITS - 1));

    logic signed [TOK_BITS-1:0] good_cnt [NUM_PROC];
    logic signed [TOK_BITS-1:0] bad_cnt [NUM_PROC];
    logic signed [TOK_BITS-1:0] good_thr [NUM_PROC];
    logic signed [TOK_BITS-1:0] bad_thr [NUM_PROC];
    // activity seen at the last update
    logic [NUM_PROC-1:0] active_q;
    logic id_ok;
    logic sel_active;

    // counter plus signed amount, clamped to the counter range
    function automatic logic signed [TOK_BITS-1:0] sat_add(
        input logic signed [TOK_BITS-1:0] cnt,
        input logic signed [NEW_BITS-1:0] amount
    );
        logic signed [TOK_BITS:0] sum;
        sum = cnt + amount;
        if (sum > CNT_MAX) return CNT_MAX[TOK_BITS-1:0];
        if (sum < CNT_MIN) return CNT_MIN[TOK_BITS-1:0];
        return sum[TOK_BITS-1:0];
    endfunction

    assign id_ok = (bus.processor_id < `TTT_PROC_ID_BITS'(NUM_PROC));
    // active once good tokens reach the threshold while bad ones stay below theirs
    assign sel_active = (good_cnt[bus.processor_id] >= good_thr[bus.processor_id])
                     && (bad_cnt[bus.processor_id] < bad_thr[bus.processor_id]);

    always_ff @(posedge clock_fast) begin
        if (reset) begin
            for (int i = 0; i < NUM_PROC; i++) begin
                good_cnt[i] <= '0;
                bad_cnt[i] <= '0;
                good_thr[i] <= TOK_BITS'(`TTT_DEFAULT_THRESHOLD);
                bad_thr[i] <= TOK_BITS'(`TTT_DEFAULT_THRESHOLD);
            end
            active_q <= '0;
            bus.startstop <= 2'b00;
        end else begin
            bus.startstop <= 2'b00;
            if (id_ok) begin
                case (bus.op)
                    PROC_SET_GOOD_THR: good_thr[bus.processor_id] <= $signed(bus.prog.value);
                    PROC_SET_BAD_THR:  bad_thr[bus.processor_id] <= $signed(bus.prog.value);
                    PROC_ADD: begin
                        good_cnt[bus.processor_id] <= sat_add(good_cnt[bus.processor_id],
                                                              bus.tokens.good);
                        bad_cnt[bus.processor_id] <= sat_add(bad_cnt[bus.processor_id],
                                                             bus.tokens.bad);
                    end
                    PROC_UPDATE: begin
                        // start on a rising edge of activity, stop on a falling one
                        bus.startstop <= {sel_active & ~active_q[bus.processor_id],
                                          ~sel_active & active_q[bus.processor_id]};
                        active_q[bus.processor_id] <= sel_active;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ttt_main testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module ttt_main_tb \
    --Mdir "$OBJ" -o ttt_main_sim -f ttt_main.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/ttt_main_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== sequencer/ttt_sequencer.sv ====
`timescale 1ns/10ps
`include "ttt_defines.svh"

module ttt_sequencer import ttt_pkg::*; (
    input  logic                                clock_fast,
    input  logic                                reset,
    input  logic [4:0]                          instruction,
    input  logic [`TTT_PROC_ID_BITS-1:0]        processor_id_in,
    input  logic [`TTT_CONN_ID_BITS-1:0]        connection_id_in,
    input  logic [`TTT_PROG_BITS-1:0]           prog_data,
    input  logic [`TTT_NEW_TOKENS_BITS-1:0]     good_tokens_in,
    input  logic [`TTT_NEW_TOKENS_BITS-1:0]     bad_tokens_in,
    output stage_e                              stage,
    output logic [`TTT_PROC_ID_BITS-1:0]        processor_id_out,
    output logic [1:0]                          token_startstop,
    output logic                                output_valid,
    ttt_net_if.master                           net,
    ttt_proc_if.master                          proc
);
    localparam int NUM_PROC = `TTT_NUM_PROCESSORS;
    localparam int ID_BITS = `TTT_PROC_ID_BITS;
    // one past the last processor, ends the scan
    localparam logic [ID_BITS-1:0] NUM_ID = ID_BITS'(NUM_PROC);
    // last update slot, only drains the pipeline
    localparam logic [ID_BITS-1:0] DRAIN_ID = ID_BITS'(NUM_PROC + 1);

    // scan index and the one before it
    logic [ID_BITS-1:0] scan_idx;
    logic [ID_BITS-1:0] prev_idx;
    // tokens emitted in the last update stage
    logic [NUM_PROC-1:0] start_buf;
    logic [NUM_PROC-1:0] stop_buf;

    always_ff @(posedge clock_fast) begin
        if (reset) begin
            stage <= STAGE_INPUT;
            scan_idx <= '0;
            prev_idx <= '0;
            output_valid <= 1'b0;
            token_startstop <= 2'b00;
            processor_id_out <= '0;
            net.op <= NET_NOP;
            proc.op <= PROC_NOP;
        end else begin
            // commands and host outputs last a single cycle
            net.op <= NET_NOP;
            proc.op <= PROC_NOP;
            output_valid <= 1'b0;
            token_startstop <= 2'b00;
            case (stage)
                STAGE_INPUT: begin
                    // host instructions only count while waiting for input
                    case (instruction[4:3])
                        `TTT_INSTR_NET: begin
                            net.op <= net_op_e'(instruction[2:0]);
                            net.source_id <= processor_id_in;
                            net.connection_id <= connection_id_in;
                            net.prog <= prog_data;
                        end
                        `TTT_INSTR_PROC: begin
                            proc.op <= proc_op_e'(instruction[2:0]);
                            proc.processor_id <= processor_id_in;
                            proc.prog <= prog_data;
                            // a programmed add takes its pair from the data word
                            proc.tokens <= prog_data;
                        end
                        default: begin
                            if (instruction[2:0] == `TTT_EXEC_READ_INPUT) begin
                                proc.op <= PROC_ADD;
                                proc.processor_id <= processor_id_in;
                                proc.tokens <= {good_tokens_in, bad_tokens_in};
                            end else if (instruction[2:0] == `TTT_EXEC_ADVANCE) begin
                                // first update goes out together with the stage change
                                stage <= STAGE_UPDATE;
                                proc.op <= PROC_UPDATE;
                                proc.processor_id <= '0;
                                scan_idx <= '0;
                                prev_idx <= '0;
                            end
                        end
                    endcase
                end
                STAGE_UPDATE: begin
                    // result of the previous id shows up one cycle late
                    if ((scan_idx != '0) && (prev_idx < NUM_ID)) begin
                        start_buf[prev_idx] <= proc.startstop[1];
                        stop_buf[prev_idx] <= proc.startstop[0];
                    end
                    if (scan_idx == DRAIN_ID) begin
                        stage <= STAGE_SCAN;
                        scan_idx <= '0;
                    end else begin
                        // no new updates once the last id has been issued
                        if (scan_idx + 1'b1 < NUM_ID) begin
                            proc.op <= PROC_UPDATE;
                            proc.processor_id <= scan_idx + 1'b1;
                        end
                        prev_idx <= scan_idx;
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
                STAGE_SCAN: begin
                    if (output_valid) begin
                        // report is out, now walk the outgoing connections
                        net.op <= NET_START;
                        net.source_id <= prev_idx;
                        stage <= STAGE_FANOUT;
                    end else if (scan_idx == NUM_ID) begin
                        // round complete
                        stage <= STAGE_INPUT;
                    end else begin
                        if (start_buf[scan_idx] ^ stop_buf[scan_idx]) begin
                            // report to the host while still in the scan
                            output_valid <= 1'b1;
                            processor_id_out <= scan_idx;
                            token_startstop <= {start_buf[scan_idx], stop_buf[scan_idx]};
                        end
                        prev_idx <= scan_idx;
                        scan_idx <= scan_idx + 1'b1;
                    end
                end
                STAGE_FANOUT: begin
                    if (net.done) begin
                        stage <= STAGE_SCAN;
                    end else begin
                        net.op <= NET_STEP;
                    end
                    if (net.valid) begin
                        proc.op <= PROC_ADD;
                        proc.processor_id <= net.target_id;
                        // a stop token takes back what the start gave
                        if (stop_buf[prev_idx]) begin
                            proc.tokens.good <= -net.weights.good;
                            proc.tokens.bad <= -net.weights.bad;
                        end else begin
                            proc.tokens <= net.weights;
                        end
                    end
                end
                default: begin
                    stage <= STAGE_INPUT;
                end
            endcase
        end
    end

endmodule

// ==== ttt_main.f ====
+incdir+common
common/ttt_pkg.sv
common/ttt_net_if.sv
common/ttt_proc_if.sv
sequencer/ttt_sequencer.sv
network/ttt_network.sv
processor/ttt_processor_array.sv
logic/ttt_main.sv
verification/ttt_main_chk.sv
verification/ttt_main_tb.sv

// ==== verification/ttt_main_chk.sv ====
`timescale 1ns/10ps

module ttt_main_chk import ttt_pkg::*; (
    input logic         clock_fast,
    input logic         reset,
    input logic [2:0]   stage,
    input logic         output_valid,
    input logic [1:0]   token_startstop
);
    // failed assertions so far, read by the testbench summary
    int failures = 0;

    // reports come out of the scan stage only
    valid_from_scan: assert property (@(posedge clock_fast) disable iff (reset)
        output_valid |-> (stage == STAGE_SCAN))
    else begin
        failures++;
        $error("output_valid raised outside the scan stage");
    end

    // exactly one of start and stop on a report
    one_token_kind: assert property (@(posedge clock_fast) disable iff (reset)
        output_valid |-> (token_startstop == 2'b10 || token_startstop == 2'b01))
    else begin
        failures++;
        $error("token_startstop is neither start nor stop on a report");
    end

    // only four stage codes exist
    stage_in_range: assert property (@(posedge clock_fast) disable iff (reset)
        stage <= 3'd3)
    else begin
        failures++;
        $error("stage code above the fan-out stage");
    end

    reset_state: assert property (@(posedge clock_fast)
        reset |=> (stage == STAGE_INPUT && !output_valid))
    else begin
        failures++;
        $error("stage or output_valid wrong right after reset");
    end

endmodule

// ==== verification/ttt_main_tb.sv ====
`timescale 1ns/10ps
`include "ttt_defines.svh"

module ttt_main_tb import ttt_pkg::*; ();
    localparam int NUM_PROC = `TTT_NUM_PROCESSORS;
    localparam int NUM_CONN = `TTT_NUM_CONNECTIONS;
    // longest round is far below this
    localparam int WAIT_LIMIT = 400;

    logic                               reset;
    logic                               clock_fast;
    logic [2:0]                         stage;
    logic [`TTT_PROC_ID_BITS-1:0]       processor_id_in;
    logic [`TTT_PROC_ID_BITS-1:0]       processor_id_out;
    logic [`TTT_NEW_TOKENS_BITS-1:0]    good_tokens_in;
    logic [`TTT_NEW_TOKENS_BITS-1:0]    bad_tokens_in;
    logic [1:0]                         token_startstop;
    logic                               output_valid;
    logic [4:0]                         instruction;
    logic [`TTT_CONN_ID_BITS-1:0]       connection_id_in;
    logic [`TTT_PROG_BITS-1:0]          prog_data;

    // reference model of the engine
    int good_m [NUM_PROC];
    int bad_m [NUM_PROC];
    int gthr_m [NUM_PROC];
    int bthr_m [NUM_PROC];
    bit act_m [NUM_PROC];
    int first_m [NUM_PROC+1];
    int tgt_m [NUM_CONN];
    logic signed [3:0] wgood_m [NUM_CONN];
    logic signed [3:0] wbad_m [NUM_CONN];
    // events packed as id then start, stop
    logic [5:0] exp_q [$];
    logic [5:0] got_q [$];
    int errors;
    int timeouts;
    integer seed;

    initial begin
        clock_fast = 1'b0;
        forever #2 clock_fast = ~clock_fast;
    end

    ttt_main UUT (
        .reset            (reset),
        .clock_fast       (clock_fast),
        .stage            (stage),
        .processor_id_in  (processor_id_in),
        .processor_id_out (processor_id_out),
        .good_tokens_in   (good_tokens_in),
        .bad_tokens_in    (bad_tokens_in),
        .token_startstop  (token_startstop),
        .output_valid     (output_valid),
        .instruction      (instruction),
        .connection_id_in (connection_id_in),
        .prog_data        (prog_data)
    );

    bind ttt_main ttt_main_chk chk (
        .clock_fast      (clock_fast),
        .reset           (reset),
        .stage           (stage),
        .output_valid    (output_valid),
        .token_startstop (token_startstop)
    );

    // outputs are settled at the falling edge
    always @(negedge clock_fast) begin
        if (output_valid) begin
            got_q.push_back({processor_id_out, token_startstop});
        end
    end

    // counters clamp at the 8 bit signed limits
    function automatic int sat_count(input int cnt, input int amount);
        int sum;
        sum = cnt + amount;
        if (sum > 127) return 127;
        if (sum < -128) return -128;
        return sum;
    endfunction

    // one instruction, held for a single cycle
    task automatic send_instr(input logic [4:0] instr, input int pid, input int cid,
                              input logic [7:0] data, input logic [3:0] good,
                              input logic [3:0] bad);
        @(posedge clock_fast);
        instruction <= instr;
        processor_id_in <= 4'(pid);
        connection_id_in <= 6'(cid);
        prog_data <= data;
        good_tokens_in <= good;
        bad_tokens_in <= bad;
        @(posedge clock_fast);
        instruction <= 5'b00000;
    endtask

    task automatic set_first(input int src, input int idx);
        send_instr(5'b11_001, src, 0, 8'(idx), 4'd0, 4'd0);
        first_m[src] = idx;
    endtask

    task automatic set_connection(input int cid, input int target,
                                  input logic signed [3:0] wg, input logic signed [3:0] wb);
        send_instr(5'b11_010, 0, cid, 8'(target), 4'd0, 4'd0);
        // weights go as one word, good in the upper half
        send_instr(5'b11_011, 0, cid, {wg, wb}, 4'd0, 4'd0);
        tgt_m[cid] = target;
        wgood_m[cid] = wg;
        wbad_m[cid] = wb;
    endtask

    task automatic set_threshold(input int pid, input bit bad_side, input int value);
        send_instr(bad_side ? 5'b10_010 : 5'b10_001, pid, 0, 8'(value), 4'd0, 4'd0);
        if (bad_side) begin
            bthr_m[pid] = value;
        end else begin
            gthr_m[pid] = value;
        end
    endtask

    task automatic inject(input int pid, input logic signed [3:0] good,
                          input logic signed [3:0] bad);
        send_instr(5'b00_001, pid, 0, 8'd0, good, bad);
        good_m[pid] = sat_count(good_m[pid], good);
        bad_m[pid] = sat_count(bad_m[pid], bad);
    endtask

    // update all, then fan out every emitted token in id order
    task automatic predict_round();
        bit now;
        int src;
        int sgn;
        exp_q.delete();
        for (int i = 0; i < NUM_PROC; i++) begin
            now = (good_m[i] >= gthr_m[i]) && (bad_m[i] < bthr_m[i]);
            if (now != act_m[i]) begin
                exp_q.push_back({4'(i), now, ~now});
                act_m[i] = now;
            end
        end
        foreach (exp_q[e]) begin
            src = exp_q[e][5:2];
            // a stop token sends the weights negated
            sgn = exp_q[e][0] ? -1 : 1;
            for (int c = first_m[src]; c < first_m[src + 1]; c++) begin
                good_m[tgt_m[c]] = sat_count(good_m[tgt_m[c]], sgn * wgood_m[c]);
                bad_m[tgt_m[c]] = sat_count(bad_m[tgt_m[c]], sgn * wbad_m[c]);
            end
        end
    endtask

    task automatic wait_stage(input bit at_input, input string what);
        int cycles;
        cycles = 0;
        // stage is only looked at between clock edges
        @(negedge clock_fast);
        while (((stage == STAGE_INPUT) != at_input) && (cycles < WAIT_LIMIT)) begin
            @(negedge clock_fast);
            cycles++;
        end
        if ((stage == STAGE_INPUT) != at_input) begin
            timeouts++;
            $display("timed out at %0t waiting for the stage to %s", $time, what);
        end
    endtask

    // advance, collect the reports and hold them against the model
    task automatic run_round();
        predict_round();
        got_q.delete();
        send_instr(5'b00_010, 0, 0, 8'd0, 4'd0, 4'd0);
        wait_stage(1'b0, "leave the input stage");
        wait_stage(1'b1, "return to the input stage");
        assert (got_q.size() == exp_q.size()) else begin
            errors++;
            $display("Fail at %0t: output_valid count expected %0d got %0d",
                     $time, exp_q.size(), got_q.size());
        end
        for (int k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
            assert (got_q[k][5:2] == exp_q[k][5:2]) else begin
                errors++;
                $display("Fail at %0t: processor_id_out expected %0d got %0d",
                         $time, exp_q[k][5:2], got_q[k][5:2]);
            end
            assert (got_q[k][1:0] == exp_q[k][1:0]) else begin
                errors++;
                $display("Fail at %0t: token_startstop expected %b got %b",
                         $time, exp_q[k][1:0], got_q[k][1:0]);
            end
            if (k > 0) begin
                assert (got_q[k][5:2] > got_q[k-1][5:2]) else begin
                    errors++;
                    $display("reported processor ids not ascending in the round at %0t",
                             $time);
                end
            end
        end
    endtask

    initial begin
        int pid;
        logic signed [3:0] g;
        logic signed [3:0] b;
        seed = 32'h1ad6;
        errors = 0;
        timeouts = 0;
        reset = 1'b1;
        instruction = 5'b00000;
        processor_id_in = '0;
        connection_id_in = '0;
        prog_data = '0;
        good_tokens_in = '0;
        bad_tokens_in = '0;
        for (int i = 0; i < NUM_PROC; i++) begin
            good_m[i] = 0;
            bad_m[i] = 0;
            gthr_m[i] = `TTT_DEFAULT_THRESHOLD;
            bthr_m[i] = `TTT_DEFAULT_THRESHOLD;
            act_m[i] = 1'b0;
        end
        for (int i = 0; i <= NUM_PROC; i++) begin
            first_m[i] = 0;
        end
        repeat (5) @(posedge clock_fast);
        reset <= 1'b0;

        // quiet round straight after reset
        run_round();

        // connection 0 links 2 to 5, sources 3 and up start at entry 1
        for (int s = 3; s <= NUM_PROC; s++) begin
            set_first(s, 1);
        end
        set_connection(0, 5, 4'sd4, 4'sd0);
        set_threshold(2, 1'b0, 3);
        inject(2, 4'sd3, 4'sd0);
        // 2 starts, then 5 follows a round later
        run_round();
        run_round();

        // bad tokens stop 2, the negated weight then stops 5
        set_threshold(2, 1'b1, 2);
        inject(2, 4'sd0, 4'sd2);
        run_round();
        run_round();

        // several random inputs per input stage
        repeat (3) begin
            repeat (6) begin
                pid = ($random(seed) & 32'h7fff_ffff) % NUM_PROC;
                g = 4'($random(seed));
                b = (($random(seed) & 3) == 0) ? 4'sd1 : 4'sd0;
                inject(pid, g, b);
            end
            run_round();
        end

        $display("errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, UUT.chk.failures);
        if (errors == 0 && timeouts == 0 && UUT.chk.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
